// ==== design/dma_pkg.sv ====
package dma_pkg;

  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int LEN_W          = 32; // bytes per transfer
  localparam int CNT_W          = 16;
  localparam int TAG_W          = 8;
  localparam int USER_W         = 65; // header plus first-pass bit
  localparam int ERR_W          = 4;  // mover status error field
  localparam int BUNDLE_DEPTH   = 8;
  localparam int BUNDLE_W       = 256;
  localparam int STORE_WR_DEPTH = 64;
  localparam int REG_COUNT      = 13;
  localparam int RAM_BASE       = 16;

  localparam int IDX_W      = $clog2(BUNDLE_DEPTH);
  localparam int WORD_AW    = $clog2(STORE_WR_DEPTH);
  localparam int WORD_SEL_W = WORD_AW - IDX_W; // word within one record
  localparam int REG_AW     = $clog2(REG_COUNT);

  // host register map, banked entries take two slots
  typedef enum logic [REG_AW-1:0] {
    A_START        = 4'd0,
    A_DONE_READ    = 4'd1,
    A_DONE_WRITE   = 4'd3,
    A_OCM_BASE     = 4'd5,
    A_WEIGHTS_BASE = 4'd7,
    A_BUNDLE_DONE  = 4'd8,
    A_N_BUNDLES    = 4'd9,
    A_W_DONE       = 4'd10,
    A_X_DONE       = 4'd11,
    A_O_DONE       = 4'd12
  } reg_addr_e;

  typedef struct packed {
    logic [USER_W-2:0] header;
    logic [CNT_W-1:0]  max_t;
    logic [CNT_W-1:0]  max_p;
    logic [LEN_W-1:0]  w_bpt;
    logic [LEN_W-1:0]  w_bpt_p0;
    logic [LEN_W-1:0]  x_bpt;
    logic [LEN_W-1:0]  x_bpt_p0;
    logic [ADDR_W-1:0] x_base; // word 0 of the record
  } bundle_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [USER_W-1:0] user;
  } desc_t;

  typedef struct packed {
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
  } host_req_t;

  typedef enum logic [1:0] {W_IDLE, W_WAIT_RAM, W_EXEC} w_state_e;

  typedef enum logic [1:0] {X_IDLE, X_WAIT_RAM, X_WAIT_WRITE, X_EXEC} x_state_e;

endpackage

// ==== design/nest_counter.sv ====
`timescale 1ns/1ps

module nest_counter import dma_pkg::*; (
  input  logic             clk,
  input  logic             rstn,
  input  logic             i_load,
  input  logic             i_en,
  input  logic [CNT_W-1:0] i_max,
  output logic [CNT_W-1:0] o_count,
  output logic             o_first,
  output logic             o_last,
  output logic             o_last_step
);

  logic [CNT_W-1:0] max_q; // kept for the wrap

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_count <= '0;
      max_q   <= '0;
    end else if (i_load) begin
      o_count <= i_max;
      max_q   <= i_max;
    end else if (i_en) begin
      o_count <= o_last ? max_q : o_count - 1'b1;
    end
  end

  assign o_first     = (o_count == max_q);
  assign o_last      = (o_count == '0);
  assign o_last_step = i_en && o_last; // steps the next loop out

endmodule

// ==== design/dma_regs.sv ====
`timescale 1ns/1ps

module dma_regs import dma_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  input  host_req_t              i_host,
  input  logic                   i_rd_en,
  input  logic [ADDR_W-1:0]      i_rd_addr,
  input  logic                   i_w_idle,
  input  logic                   i_x_idle,
  input  logic                   i_x_wait_write,
  input  logic                   i_bank_claim,
  input  logic                   i_bank_idx,
  input  logic                   i_wr_ok,
  input  logic [TAG_W-1:0]       i_wr_tag,
  input  logic                   i_o_done_set,
  input  logic                   i_o_done_clr,
  output logic                   o_wr_ack,
  output logic                   o_rd_ack,
  output logic [DATA_W-1:0]      o_rd_data,
  output logic                   o_start,
  output logic                   o_bundle_done,
  output logic [ADDR_W-1:0]      o_weights_base,
  output logic [DATA_W-1:0]      o_n_bundles,
  output logic [1:0][ADDR_W-1:0] o_ocm_base,
  output logic [1:0]             o_done_read
);

  logic [REG_COUNT-1:0][DATA_W-1:0] cfg;
  logic                             host_wr;

  assign host_wr = i_host.wr_en && (i_host.wr_addr < ADDR_W'(REG_COUNT));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg                          <= '0;
      cfg[A_DONE_READ]             <= DATA_W'(1); // both banks free at reset
      cfg[int'(A_DONE_READ) + 1]   <= DATA_W'(1);
      cfg[A_BUNDLE_DONE]           <= DATA_W'(1); // first bundle needs no host flag
    end else begin
      if (o_start)
        cfg[A_START] <= '0; // one-cycle pulse
      if (o_bundle_done && i_x_wait_write)
        cfg[A_BUNDLE_DONE] <= '0; // consumed by pixels sequencer
      cfg[A_W_DONE] <= DATA_W'(i_w_idle);
      cfg[A_X_DONE] <= DATA_W'(i_x_idle);

      if (i_o_done_clr)
        cfg[A_O_DONE] <= '0;
      else if (i_o_done_set)
        cfg[A_O_DONE] <= DATA_W'(1);

      // output controller took the bank, host must read it back again
      if (i_bank_claim) begin
        cfg[int'(A_DONE_READ) + int'(i_bank_idx)]  <= '0;
        cfg[int'(A_DONE_WRITE) + int'(i_bank_idx)] <= '0;
      end
      if (i_wr_ok && (i_wr_tag < TAG_W'(2)))
        cfg[int'(A_DONE_WRITE) + int'(i_wr_tag)] <= DATA_W'(1);

      if (host_wr)
        cfg[i_host.wr_addr[REG_AW-1:0]] <= i_host.wr_data; // host wins
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_wr_ack <= 1'b0;
      o_rd_ack <= 1'b0;
    end else begin
      o_wr_ack <= i_host.wr_en; // store writes are acked here too
      o_rd_ack <= i_rd_en;
    end
  end

  // bundle store is write-only, anything past the registers reads zero
  always_ff @(posedge clk) begin
    if (i_rd_en)
      o_rd_data <= (i_rd_addr < ADDR_W'(REG_COUNT)) ? cfg[i_rd_addr[REG_AW-1:0]] : '0;
  end

  assign o_start        = cfg[A_START][0];
  assign o_bundle_done  = cfg[A_BUNDLE_DONE][0];
  assign o_weights_base = cfg[A_WEIGHTS_BASE];
  assign o_n_bundles    = cfg[A_N_BUNDLES];
  assign o_ocm_base[0]  = cfg[A_OCM_BASE];
  assign o_ocm_base[1]  = cfg[int'(A_OCM_BASE) + 1];
  assign o_done_read    = {cfg[int'(A_DONE_READ) + 1][0], cfg[A_DONE_READ][0]};

endmodule

// ==== design/bundle_store.sv ====
`timescale 1ns/1ps

module bundle_store import dma_pkg::*; (
  input  logic             clk,
  input  logic             rstn,
  input  host_req_t        i_host,
  input  logic             i_x_req,
  input  logic [IDX_W-1:0] i_x_idx,
  input  logic             i_w_req,
  input  logic [IDX_W-1:0] i_w_idx,
  output bundle_t          o_rec,
  output logic             o_x_valid,
  output logic             o_w_valid
);

  // one row per record, written a word at a time
  logic [BUNDLE_W/DATA_W-1:0][DATA_W-1:0] mem [BUNDLE_DEPTH];

  logic               wr_hit;
  logic [WORD_AW-1:0] wr_word;
  logic [IDX_W-1:0]   rd_idx;

  assign wr_hit  = i_host.wr_en && (i_host.wr_addr >= ADDR_W'(RAM_BASE)) &&
                   (i_host.wr_addr < ADDR_W'(RAM_BASE + STORE_WR_DEPTH));
  assign wr_word = WORD_AW'(i_host.wr_addr - ADDR_W'(RAM_BASE));
  assign rd_idx  = i_x_req ? i_x_idx : i_w_idx; // pixels first

  always_ff @(posedge clk) begin
    if (wr_hit)
      mem[wr_word[WORD_AW-1 -: IDX_W]][wr_word[WORD_SEL_W-1:0]] <= i_host.wr_data;
    if (i_x_req || i_w_req)
      o_rec <= bundle_t'(mem[rd_idx]);
  end

  // valid goes only to the reader that was granted
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_x_valid <= 1'b0;
      o_w_valid <= 1'b0;
    end else begin
      o_x_valid <= i_x_req;
      o_w_valid <= i_w_req && !i_x_req;
    end
  end

endmodule

// ==== design/weights_desc_seq.sv ====
`timescale 1ns/1ps

module weights_desc_seq import dma_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              i_start,
  input  logic [ADDR_W-1:0] i_weights_base,
  input  logic [DATA_W-1:0] i_n_bundles,
  input  bundle_t           i_rec,
  input  logic              i_rec_valid,
  input  logic              i_ready,
  output logic              o_req,
  output logic [IDX_W-1:0]  o_idx,
  output desc_t             o_desc,
  output logic              o_valid,
  output logic              o_idle
);

  w_state_e          state, state_nxt;
  logic [USER_W-2:0] header;
  logic [LEN_W-1:0]  bpt, bpt_p0, len;
  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  count_b;
  logic              xfer, lc_t, lc_p, lc_b, first_p;

  always_comb begin
    state_nxt = state;
    case (state)
      W_IDLE:     if (i_start) state_nxt = W_WAIT_RAM;
      W_WAIT_RAM: if (i_rec_valid) state_nxt = W_EXEC;
      W_EXEC: begin
        if (lc_b)
          state_nxt = W_IDLE; // all bundles sent
        else if (lc_p)
          state_nxt = W_WAIT_RAM; // fetch next record
      end
      default:    state_nxt = W_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn)
      state <= W_IDLE;
    else
      state <= state_nxt;
  end

  assign o_valid = (state == W_EXEC);
  assign o_idle  = (state == W_IDLE);
  assign o_req   = (state == W_WAIT_RAM) && !i_rec_valid; // drop once granted
  assign o_idx   = IDX_W'(i_n_bundles - 1 - DATA_W'(count_b)); // count runs down
  assign xfer    = o_valid && i_ready;
  assign len     = first_p ? bpt_p0 : bpt;
  assign o_desc  = '{addr: addr_q, len: len, user: {header, first_p}};

  // address runs on across bundles
  always_ff @(posedge clk) begin
    if (!rstn)
      addr_q <= '0;
    else if (i_start)
      addr_q <= i_weights_base;
    else if (xfer)
      addr_q <= addr_q + ADDR_W'(len);
  end

  always_ff @(posedge clk) begin
    if (i_rec_valid) begin
      header <= i_rec.header;
      bpt_p0 <= i_rec.w_bpt_p0;
      bpt    <= i_rec.w_bpt;
    end
  end

  nest_counter u_cnt_t (
    .clk, .rstn, .i_load(i_rec_valid), .i_en(xfer), .i_max(CNT_W'(i_rec.max_t - 1'b1)),
    .o_count(), .o_first(), .o_last(), .o_last_step(lc_t)
  );

  nest_counter u_cnt_p (
    .clk, .rstn, .i_load(i_rec_valid), .i_en(lc_t), .i_max(CNT_W'(i_rec.max_p - 1'b1)),
    .o_count(), .o_first(first_p), .o_last(), .o_last_step(lc_p)
  );

  nest_counter u_cnt_b (
    .clk, .rstn, .i_load(i_start), .i_en(lc_p), .i_max(CNT_W'(i_n_bundles - 1)),
    .o_count(count_b), .o_first(), .o_last(), .o_last_step(lc_b)
  );

endmodule

// ==== design/pixels_desc_seq.sv ====
`timescale 1ns/1ps

module pixels_desc_seq import dma_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              i_start,
  input  logic [DATA_W-1:0] i_n_bundles,
  input  logic              i_bundle_done,
  input  bundle_t           i_rec,
  input  logic              i_rec_valid,
  input  logic              i_ready,
  output logic              o_req,
  output logic [IDX_W-1:0]  o_idx,
  output desc_t             o_desc,
  output logic              o_valid,
  output logic              o_idle,
  output logic              o_wait_write
);

  x_state_e          state, state_nxt;
  logic [USER_W-2:0] header;
  logic [LEN_W-1:0]  bpt, bpt_p0, len;
  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  count_b;
  logic              xfer, lc_t, lc_p, lc_b, first_p;

  always_comb begin
    state_nxt = state;
    case (state)
      X_IDLE:       if (i_start) state_nxt = X_WAIT_RAM;
      X_WAIT_RAM:   if (i_rec_valid) state_nxt = X_WAIT_WRITE;
      X_WAIT_WRITE: if (i_bundle_done) state_nxt = X_EXEC; // host has filled the input
      X_EXEC: begin
        if (lc_b)
          state_nxt = X_IDLE;
        else if (lc_p)
          state_nxt = X_WAIT_RAM;
      end
      default:      state_nxt = X_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn)
      state <= X_IDLE;
    else
      state <= state_nxt;
  end

  assign o_valid      = (state == X_EXEC);
  assign o_idle       = (state == X_IDLE);
  assign o_wait_write = (state == X_WAIT_WRITE);
  assign o_req        = (state == X_WAIT_RAM) && !i_rec_valid;
  assign o_idx        = IDX_W'(i_n_bundles - 1 - DATA_W'(count_b));
  assign xfer         = o_valid && i_ready;
  assign len          = first_p ? bpt_p0 : bpt;
  assign o_desc       = '{addr: addr_q, len: len, user: {header, first_p}};

  // every transfer of a pass rereads the same pixels
  always_ff @(posedge clk) begin
    if (!rstn)
      addr_q <= '0;
    else if (i_rec_valid)
      addr_q <= i_rec.x_base;
    else if (lc_t)
      addr_q <= addr_q + ADDR_W'(len); // once per pass
  end

  always_ff @(posedge clk) begin
    if (i_rec_valid) begin
      header <= i_rec.header;
      bpt_p0 <= i_rec.x_bpt_p0;
      bpt    <= i_rec.x_bpt;
    end
  end

  nest_counter u_cnt_t (
    .clk, .rstn, .i_load(i_rec_valid), .i_en(xfer), .i_max(CNT_W'(i_rec.max_t - 1'b1)),
    .o_count(), .o_first(), .o_last(), .o_last_step(lc_t)
  );

  nest_counter u_cnt_p (
    .clk, .rstn, .i_load(i_rec_valid), .i_en(lc_t), .i_max(CNT_W'(i_rec.max_p - 1'b1)),
    .o_count(), .o_first(first_p), .o_last(), .o_last_step(lc_p)
  );

  nest_counter u_cnt_b (
    .clk, .rstn, .i_load(i_start), .i_en(lc_p), .i_max(CNT_W'(i_n_bundles - 1)),
    .o_count(count_b), .o_first(), .o_last(), .o_last_step(lc_b)
  );

endmodule

// ==== design/output_desc_ctrl.sv ====
`timescale 1ns/1ps

module output_desc_ctrl import dma_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   i_start,
  input  logic                   i_o_valid,
  input  logic                   i_o_ready,
  input  logic                   i_o_last,
  input  logic [LEN_W-1:0]       i_o_bpt,
  input  logic [1:0][ADDR_W-1:0] i_ocm_base,
  input  logic [1:0]             i_done_read,
  input  logic                   i_os_valid,
  input  logic [ERR_W-1:0]       i_os_error,
  input  logic [TAG_W-1:0]       i_os_tag,
  input  logic                   i_ready,
  output logic [ADDR_W-1:0]      o_desc_addr,
  output logic [LEN_W-1:0]       o_desc_len,
  output logic [TAG_W-1:0]       o_desc_tag,
  output logic                   o_valid,
  output logic                   o_bank_claim,
  output logic                   o_bank_idx,
  output logic                   o_wr_ok,
  output logic [TAG_W-1:0]       o_wr_tag,
  output logic                   o_o_done_set,
  output logic                   o_o_done_clr
);

  logic bank_q;   // bank the mover is writing
  logic got_last; // engine stream is between packets, so o_bpt belongs to a new one

  assign o_bank_idx   = !bank_q;
  assign o_bank_claim = i_ready && i_o_valid && got_last && !o_valid &&
                        i_done_read[o_bank_idx]; // next bank must be read back first
  assign o_desc_tag   = TAG_W'(bank_q);
  assign o_wr_ok      = i_os_valid && (i_os_error == '0);
  assign o_wr_tag     = i_os_tag;
  assign o_o_done_clr = i_start || i_o_valid; // engine still has data
  assign o_o_done_set = got_last && o_wr_ok;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bank_q   <= 1'b1; // so the first claim lands on bank 0
      got_last <= 1'b1;
      o_valid  <= 1'b0;
    end else begin
      if (i_o_valid && i_o_ready && i_o_last)
        got_last <= 1'b1;
      if (o_bank_claim) begin
        bank_q   <= o_bank_idx;
        got_last <= 1'b0;
        o_valid  <= 1'b1;
      end else if (o_valid && i_ready) begin
        o_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (o_bank_claim) begin
      o_desc_addr <= i_ocm_base[o_bank_idx];
      o_desc_len  <= i_o_bpt;
    end
  end

endmodule

// ==== design/dma_controller.sv ====
`timescale 1ns/1ps

module dma_controller import dma_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  host_req_t         i_host,
  input  logic              i_rd_en,
  input  logic [ADDR_W-1:0] i_rd_addr,
  output logic              o_wr_ack,
  output logic              o_rd_ack,
  output logic [DATA_W-1:0] o_rd_data,
  input  logic              i_o_valid, // engine output stream, monitored only
  input  logic              i_o_ready,
  input  logic              i_o_last,
  input  logic [LEN_W-1:0]  i_o_bpt,
  input  logic              i_os_valid, // mover write status
  input  logic [ERR_W-1:0]  i_os_error,
  input  logic [TAG_W-1:0]  i_os_tag,
  output desc_t             o_w_desc,
  output logic              o_w_valid,
  input  logic              i_w_ready,
  output desc_t             o_x_desc,
  output logic              o_x_valid,
  input  logic              i_x_ready,
  output logic [ADDR_W-1:0] o_od_addr,
  output logic [LEN_W-1:0]  o_od_len,
  output logic [TAG_W-1:0]  o_od_tag,
  output logic              o_od_valid,
  input  logic              i_od_ready
);

  logic                   start, bundle_done, w_idle, x_idle, x_wait_write;
  logic                   bank_claim, bank_idx, wr_ok, o_done_set, o_done_clr;
  logic                   x_req, w_req, x_rec_valid, w_rec_valid;
  logic [TAG_W-1:0]       wr_tag;
  logic [ADDR_W-1:0]      weights_base;
  logic [DATA_W-1:0]      n_bundles;
  logic [1:0][ADDR_W-1:0] ocm_base;
  logic [1:0]             done_read;
  logic [IDX_W-1:0]       x_idx, w_idx;
  bundle_t                rec;

  dma_regs u_regs (
    .clk, .rstn, .i_host, .i_rd_en, .i_rd_addr,
    .i_w_idle(w_idle), .i_x_idle(x_idle), .i_x_wait_write(x_wait_write),
    .i_bank_claim(bank_claim), .i_bank_idx(bank_idx), .i_wr_ok(wr_ok), .i_wr_tag(wr_tag),
    .i_o_done_set(o_done_set), .i_o_done_clr(o_done_clr),
    .o_wr_ack, .o_rd_ack, .o_rd_data, .o_start(start), .o_bundle_done(bundle_done),
    .o_weights_base(weights_base), .o_n_bundles(n_bundles),
    .o_ocm_base(ocm_base), .o_done_read(done_read)
  );

  bundle_store u_store (
    .clk, .rstn, .i_host,
    .i_x_req(x_req), .i_x_idx(x_idx), .i_w_req(w_req), .i_w_idx(w_idx),
    .o_rec(rec), .o_x_valid(x_rec_valid), .o_w_valid(w_rec_valid)
  );

  weights_desc_seq u_w_seq (
    .clk, .rstn, .i_start(start), .i_weights_base(weights_base), .i_n_bundles(n_bundles),
    .i_rec(rec), .i_rec_valid(w_rec_valid), .i_ready(i_w_ready),
    .o_req(w_req), .o_idx(w_idx), .o_desc(o_w_desc), .o_valid(o_w_valid), .o_idle(w_idle)
  );

  pixels_desc_seq u_x_seq (
    .clk, .rstn, .i_start(start), .i_n_bundles(n_bundles), .i_bundle_done(bundle_done),
    .i_rec(rec), .i_rec_valid(x_rec_valid), .i_ready(i_x_ready),
    .o_req(x_req), .o_idx(x_idx), .o_desc(o_x_desc), .o_valid(o_x_valid), .o_idle(x_idle),
    .o_wait_write(x_wait_write)
  );

  output_desc_ctrl u_out_ctrl (
    .clk, .rstn, .i_start(start), .i_o_valid, .i_o_ready, .i_o_last, .i_o_bpt,
    .i_ocm_base(ocm_base), .i_done_read(done_read),
    .i_os_valid, .i_os_error, .i_os_tag, .i_ready(i_od_ready),
    .o_desc_addr(o_od_addr), .o_desc_len(o_od_len), .o_desc_tag(o_od_tag),
    .o_valid(o_od_valid), .o_bank_claim(bank_claim), .o_bank_idx(bank_idx),
    .o_wr_ok(wr_ok), .o_wr_tag(wr_tag), .o_o_done_set(o_done_set), .o_o_done_clr(o_done_clr)
  );

endmodule

// ==== dv/dma_asserts.sv ====
`timescale 1ns/1ps

module dma_asserts import dma_pkg::*; (
  input logic  clk,
  input logic  rstn,
  input logic  i_valid,
  input logic  i_ready,
  input desc_t i_payload,
  input logic  i_pulse
);

  // descriptor must hold until the mover takes it
  property p_hold_under_backpressure;
    @(posedge clk) disable iff (!rstn)
      (i_valid && !i_ready) |=> (i_valid && $stable(i_payload));
  endproperty

  property p_single_cycle_pulse;
    @(posedge clk) disable iff (!rstn) i_pulse |=> !i_pulse;
  endproperty

  a_hold: assert property (p_hold_under_backpressure)
    else $error("descriptor changed or dropped while ready was low");
  a_pulse: assert property (p_single_cycle_pulse)
    else $error("pulse held longer than one cycle");

endmodule

bind weights_desc_seq dma_asserts u_w_asserts (
  .clk, .rstn, .i_valid(o_valid), .i_ready(i_ready), .i_payload(o_desc), .i_pulse(i_start)
);

bind pixels_desc_seq dma_asserts u_x_asserts (
  .clk, .rstn, .i_valid(o_valid), .i_ready(i_ready), .i_payload(o_desc), .i_pulse(i_start)
);

bind output_desc_ctrl dma_asserts u_od_asserts (
  .clk, .rstn, .i_valid(o_valid), .i_ready(i_ready),
  .i_payload(desc_t'({o_desc_addr, o_desc_len, USER_W'(o_desc_tag)})), .i_pulse(o_wr_ok)
);

// ==== dv/dma_tb.sv ====
`timescale 1ns/1ps

module dma_tb import dma_pkg::*; ();

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } reg_wr_t;

  logic              clk = 1'b0;
  logic              rstn;
  host_req_t         host;
  logic              rd_en, wr_ack, rd_ack;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;
  logic              eng_valid, eng_ready, eng_last, os_valid;
  logic [LEN_W-1:0]  eng_bpt;
  logic [ERR_W-1:0]  os_error;
  logic [TAG_W-1:0]  os_tag, od_tag;
  desc_t             w_desc, x_desc;
  logic              w_valid, w_ready, x_valid, x_ready, od_valid, od_ready;
  logic [ADDR_W-1:0] od_addr;
  logic [LEN_W-1:0]  od_len;

  logic [31:0] lfsr = 32'h6e2bdaf3;
  bundle_t     bundles [3];
  reg_wr_t     reg_table [4];
  desc_t       w_exp [$];
  desc_t       x_exp [$];
  int          x_bundle_end [3];
  int          od_tags [3] = '{0, 1, 0};
  bit          bd_written [3];
  int          test_errs [5];
  int          w_cnt, x_cnt, od_cnt, checks, errors;
  bit          checking, model_built;

  dma_controller u_dut (
    .clk, .rstn, .i_host(host), .i_rd_en(rd_en), .i_rd_addr(rd_addr),
    .o_wr_ack(wr_ack), .o_rd_ack(rd_ack), .o_rd_data(rd_data),
    .i_o_valid(eng_valid), .i_o_ready(eng_ready), .i_o_last(eng_last), .i_o_bpt(eng_bpt),
    .i_os_valid(os_valid), .i_os_error(os_error), .i_os_tag(os_tag),
    .o_w_desc(w_desc), .o_w_valid(w_valid), .i_w_ready(w_ready),
    .o_x_desc(x_desc), .o_x_valid(x_valid), .i_x_ready(x_ready),
    .o_od_addr(od_addr), .o_od_len(od_len), .o_od_tag(od_tag),
    .o_od_valid(od_valid), .i_od_ready(od_ready)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per ready bit
  always @(posedge clk) begin
    lfsr = lfsr_next(lfsr);
    w_ready <= lfsr[0];
    lfsr = lfsr_next(lfsr);
    x_ready <= lfsr[0];
    lfsr = lfsr_next(lfsr);
    od_ready <= lfsr[0];
  end

  task automatic compare_field(input int t, input string name,
                               input logic [USER_W-1:0] got, input logic [USER_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      test_errs[t]++;
      $display("mismatch %s: got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_desc(input int t, input string name, input desc_t got, input desc_t exp);
    compare_field(t, {name, ".addr"}, USER_W'(got.addr), USER_W'(exp.addr));
    compare_field(t, {name, ".len"}, USER_W'(got.len), USER_W'(exp.len));
    compare_field(t, {name, ".user"}, got.user, exp.user);
  endtask

  // pass 0 of each bundle uses the p0 lengths
  task automatic build_model();
    logic [ADDR_W-1:0] waddr, xaddr;
    logic [LEN_W-1:0]  wlen, xlen;
    waddr = reg_table[0].data;
    for (int b = 0; b < 3; b++) begin
      xaddr = bundles[b].x_base;
      for (int p = 0; p < int'(bundles[b].max_p); p++) begin
        wlen = (p == 0) ? bundles[b].w_bpt_p0 : bundles[b].w_bpt;
        xlen = (p == 0) ? bundles[b].x_bpt_p0 : bundles[b].x_bpt;
        for (int t = 0; t < int'(bundles[b].max_t); t++) begin
          w_exp.push_back('{addr: waddr, len: wlen, user: {bundles[b].header, p == 0}});
          x_exp.push_back('{addr: xaddr, len: xlen, user: {bundles[b].header, p == 0}});
          waddr = waddr + wlen;
        end
        xaddr = xaddr + xlen; // pixels step once per pass
      end
      x_bundle_end[b] = x_exp.size();
    end
    model_built = 1'b1;
  endtask

  always @(negedge clk) begin
    if (rstn && checking && w_valid && w_ready) begin
      if (w_cnt >= w_exp.size()) begin
        test_errs[1]++;
        $display("error: weights descriptor beyond the expected count");
      end else
        check_desc(1, "w_desc", w_desc, w_exp[w_cnt]);
      w_cnt++;
    end
  end

  always @(negedge clk) begin
    if (rstn && checking && x_valid && x_ready) begin
      if (x_cnt >= x_exp.size()) begin
        test_errs[2]++;
        $display("error: pixels descriptor beyond the expected count");
      end else begin
        for (int b = 1; b < 3; b++)
          if (x_cnt >= x_bundle_end[b-1] && x_cnt < x_bundle_end[b] && !bd_written[b]) begin
            test_errs[2]++;
            $display("error: pixels bundle %0d issued before bundle done", b);
          end
        check_desc(2, "x_desc", x_desc, x_exp[x_cnt]);
      end
      x_cnt++;
    end
  end

  always @(negedge clk) begin
    if (rstn && checking && od_valid && od_ready) begin
      if (od_cnt >= 3) begin
        test_errs[3]++;
        $display("error: output descriptor beyond the expected count");
      end else begin
        compare_field(3, "od_tag", USER_W'(od_tag), USER_W'(od_tags[od_cnt]));
        compare_field(3, "od_addr", USER_W'(od_addr),
                      USER_W'(reg_table[2 + od_tags[od_cnt]].data));
        compare_field(3, "od_len", USER_W'(od_len), USER_W'(eng_bpt));
      end
      od_cnt++;
    end
  end

  task automatic host_write(input int t, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
    @(posedge clk);
    host <= '{wr_en: 1'b1, wr_addr: addr, wr_data: data};
    @(posedge clk);
    host.wr_en <= 1'b0;
    @(negedge clk);
    checks++;
    if (!wr_ack) begin
      test_errs[t]++;
      $display("error: write to %h was not acknowledged", addr);
    end
  endtask

  task automatic host_read(input int t, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] exp);
    @(posedge clk);
    rd_en   <= 1'b1;
    rd_addr <= addr;
    @(posedge clk);
    rd_en <= 1'b0;
    @(negedge clk);
    checks++;
    if (!rd_ack) begin
      test_errs[t]++;
      $display("error: read of %h was not acknowledged", addr);
    end
    compare_field(t, $sformatf("rd_data[%0d]", addr), USER_W'(rd_data), USER_W'(exp));
  endtask

  task automatic mover_status(input logic [TAG_W-1:0] tag);
    @(posedge clk);
    os_valid <= 1'b1;
    os_tag   <= tag;
    os_error <= '0;
    @(posedge clk);
    os_valid <= 1'b0;
  endtask

  task automatic report(input int t, input string name);
    $display("test %0d %s: %s (%0d errors)", t, name,
             (test_errs[t] == 0) ? "ok" : "failed", test_errs[t]);
  endtask

  initial begin
    wait (model_built);
    repeat ((w_exp.size() + x_exp.size() + 3) * 40 + 2000) @(posedge clk);
    $display("timeout: descriptor streams did not complete in time");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    rstn      = 1'b0;
    host      = '0;
    rd_en     = 1'b0;
    rd_addr   = '0;
    eng_valid = 1'b0;
    eng_ready = 1'b0;
    eng_last  = 1'b0;
    eng_bpt   = 32'h40;
    os_valid  = 1'b0;
    os_error  = '0;
    os_tag    = '0;
    w_ready   = 1'b0;
    x_ready   = 1'b0;
    od_ready  = 1'b0;
    reg_table = '{'{7, 32'h2000_0000}, '{9, 3}, '{5, 32'h3000_0000}, '{6, 32'h3000_8000}};
    bundles[0] = '{header: 64'haaaa_0000_0000_0001, max_t: 16'd2, max_p: 16'd2,
                   w_bpt: 32'h100, w_bpt_p0: 32'h80, x_bpt: 32'h40, x_bpt_p0: 32'h20,
                   x_base: 32'h1000_0000};
    bundles[1] = '{header: 64'hbbbb_0000_0000_0002, max_t: 16'd3, max_p: 16'd1,
                   w_bpt: 32'h200, w_bpt_p0: 32'h180, x_bpt: 32'h60, x_bpt_p0: 32'h30,
                   x_base: 32'h1100_0000};
    bundles[2] = '{header: 64'hcccc_0000_0000_0003, max_t: 16'd1, max_p: 16'd3,
                   w_bpt: 32'h40, w_bpt_p0: 32'h20, x_bpt: 32'h10, x_bpt_p0: 32'h8,
                   x_base: 32'h1200_0000};
    build_model();
    repeat (2) @(posedge clk);
    rstn <= 1'b1;

    foreach (reg_table[i]) begin
      host_read(0, reg_table[i].addr, '0);
    end
    host_read(0, 1, 1);
    host_read(0, 2, 1);
    host_read(0, 3, 0);
    host_read(0, 4, 0);
    host_read(0, 8, 1);
    host_read(0, 0, 0);
    host_read(0, 12, 0);
    host_read(0, 13, 0);
    foreach (reg_table[i]) begin
      host_write(0, reg_table[i].addr, reg_table[i].data);
      host_read(0, reg_table[i].addr, reg_table[i].data);
    end
    // eight words per record with word 0 in the low bits
    for (int b = 0; b < 3; b++)
      for (int w = 0; w < 8; w++)
        host_write(0, RAM_BASE + b * 8 + w, bundles[b][w*32 +: 32]);
    report(0, "register access");

    checking = 1'b1;
    host_write(1, 0, 1);
    for (int b = 1; b < 3; b++) begin
      wait (x_cnt == x_bundle_end[b-1]);
      repeat (20) @(posedge clk);
      checks++;
      if (x_cnt != x_bundle_end[b-1]) begin
        test_errs[2]++;
        $display("error: pixels advanced without bundle done");
      end
      bd_written[b] = 1'b1;
      host_write(2, 8, 1);
    end

    @(posedge clk);
    eng_valid <= 1'b1;
    eng_ready <= 1'b1;
    eng_last  <= 1'b1;
    wait (od_cnt == 2);
    repeat (30) @(posedge clk);
    checks++;
    if (od_cnt != 2) begin
      test_errs[3]++;
      $display("error: output controller claimed a bank the host had not read back");
    end
    mover_status(0);
    host_read(3, 3, 1);
    host_read(3, 1, 0);
    host_write(3, 1, 1);
    wait (od_cnt == 3);
    repeat (2) @(posedge clk);
    eng_valid <= 1'b0;
    mover_status(1);
    host_read(3, 4, 1);

    wait (w_cnt == w_exp.size() && x_cnt == x_exp.size());
    repeat (5) @(posedge clk);
    compare_field(1, "weights count", USER_W'(w_cnt), USER_W'(w_exp.size()));
    report(1, "weights stream");
    compare_field(2, "pixels count", USER_W'(x_cnt), USER_W'(x_exp.size()));
    report(2, "pixels stream");
    compare_field(3, "output count", USER_W'(od_cnt), USER_W'(3));
    report(3, "output banks");

    host_read(4, 10, 1);
    host_read(4, 11, 1);
    host_read(4, 12, 1);
    checking = 1'b0;
    host_write(4, 0, 1);
    repeat (3) @(posedge clk);
    host_read(4, 10, 0);
    host_read(4, 11, 0);
    host_read(4, 12, 0);
    report(4, "done flags");

    foreach (test_errs[i])
      errors += test_errs[i];
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== dma_controller.f ====
design/dma_pkg.sv
design/nest_counter.sv
design/dma_regs.sv
design/bundle_store.sv
design/weights_desc_seq.sv
design/pixels_desc_seq.sv
design/output_desc_ctrl.sv
design/dma_controller.sv
dv/dma_asserts.sv
dv/dma_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dma_tb
FLIST     ?= dma_controller.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Done: no errors" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
